/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int XLEN       = 32;
    localparam int ORDER_W    = 64;
    localparam int REG_ADDR_W = 5;
    localparam int MASK_W     = 4;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 encodings, anything else is illegal
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } f3_load_e;

    typedef enum logic [2:0] {
        SB = 3'b000,
        SH = 3'b001,
        SW = 3'b010
    } f3_store_e;

    // instruction as it leaves execute
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] alu_out;  // also the effective address
        logic [XLEN-1:0] rs2_val;  // store data
    } exe_result_t;

    typedef struct packed {
        logic [ORDER_W-1:0] order;
        exe_result_t        exe;
    } stamped_t;

    // memory stage register content
    typedef struct packed {
        logic [ORDER_W-1:0]    order;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
        logic [XLEN-1:0]       alu_out;
        logic [XLEN-1:0]       mem_addr;   // word aligned
        logic [MASK_W-1:0]     rmask;
        logic [MASK_W-1:0]     wmask;
        logic [XLEN-1:0]       mem_wdata;
        logic                  is_load;
        logic                  is_store;
        logic                  trap;
        logic [REG_ADDR_W-1:0] rd_addr;
    } mem_stage_t;

    // one retired instruction
    typedef struct packed {
        logic [ORDER_W-1:0]    order;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rd_wdata;
        logic [XLEN-1:0]       mem_addr;
        logic [MASK_W-1:0]     rmask;
        logic [MASK_W-1:0]     wmask;
        logic [XLEN-1:0]       mem_wdata;
        logic                  trap;
    } commit_t;

endpackage : pipe_pkg

`default_nettype wire

/* logic/stage_reg.sv */
`default_nettype none
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst,

    input  wire      in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  wire      out_ready_i,
    output payload_t out_data_o
);

    logic     full_q;
    payload_t data_q;
    logic     load;

    // accept when empty or when the held entry drains this cycle
    assign in_ready_o = !full_q || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            full_q <= 1'b0;  // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

    // a stalled entry must hold until the consumer takes it
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
    );

endmodule : stage_reg

`default_nettype wire

/* logic/order_stamp.sv */
`default_nettype none
`timescale 1ns/10ps

module order_stamp (
    input  wire                   clk,
    input  wire                   rst,

    input  wire                   in_valid_i,
    output logic                  in_ready_o,
    input  pipe_pkg::exe_result_t in_data_i,

    output logic                  out_valid_o,
    input  wire                   out_ready_i,
    output pipe_pkg::stamped_t    out_data_o
);

    import pipe_pkg::*;

    logic [ORDER_W-1:0] order_q;
    stamped_t           stamped;
    logic               take;

    assign stamped.order = order_q;  // value before the increment
    assign stamped.exe   = in_data_i;
    assign take          = in_valid_i && in_ready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            order_q <= '0;
        end else if (take) begin
            order_q <= order_q + ORDER_W'(1);
        end
    end

    stage_reg #(
        .payload_t (stamped_t)
    ) stage_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (stamped),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

    // order numbers only advance on an accepted instruction
    a_order_step: assert property (
        @(posedge clk) disable iff (rst)
        !take |=> $stable(order_q)
    );

endmodule : order_stamp

`default_nettype wire

/* logic/mem_request_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_request_stage (
    input  wire                              clk,
    input  wire                              rst,

    input  wire                              in_valid_i,
    output logic                             in_ready_o,
    input  pipe_pkg::stamped_t               in_data_i,

    output logic                             dmem_req_valid_o,
    input  wire                              dmem_req_ready_i,
    output logic [pipe_pkg::XLEN-1:0]        dmem_addr_o,
    output logic                             dmem_we_o,
    output logic [pipe_pkg::MASK_W-1:0]      dmem_mask_o,
    output logic [pipe_pkg::XLEN-1:0]        dmem_wdata_o,

    output logic                             out_valid_o,
    input  wire                              out_ready_i,
    output pipe_pkg::mem_stage_t             out_data_o
);

    import pipe_pkg::*;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [1:0]        offs;
    logic              is_load;
    logic              is_store;
    logic [MASK_W-1:0] size_mask;  // unshifted access width
    logic [MASK_W-1:0] mask;
    logic              bad;
    mem_stage_t        entry_d;
    logic              reg_valid;
    logic              mem_access;
    logic              advance;

    assign opcode   = in_data_i.exe.instr[6:0];
    assign funct3   = in_data_i.exe.instr[14:12];
    assign offs     = in_data_i.exe.alu_out[1:0];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    always_comb begin
        size_mask = '0;
        bad       = 1'b0;
        if (is_load) begin
            case (f3_load_e'(funct3))
                LB, LBU: size_mask = 4'b0001;
                LH, LHU: begin
                    size_mask = 4'b0011;
                    bad       = offs[0];  // odd halfword
                end
                LW: begin
                    size_mask = 4'b1111;
                    bad       = (offs != 2'b00);
                end
                default: bad = 1'b1;
            endcase
        end else if (is_store) begin
            case (f3_store_e'(funct3))
                SB: size_mask = 4'b0001;
                SH: begin
                    size_mask = 4'b0011;
                    bad       = offs[0];
                end
                SW: begin
                    size_mask = 4'b1111;
                    bad       = (offs != 2'b00);
                end
                default: bad = 1'b1;
            endcase
        end
    end

    assign mask = bad ? '0 : (size_mask << offs);

    always_comb begin
        entry_d.order     = in_data_i.order;
        entry_d.pc        = in_data_i.exe.pc;
        entry_d.instr     = in_data_i.exe.instr;
        entry_d.alu_out   = in_data_i.exe.alu_out;
        entry_d.mem_addr  = (is_load || is_store) ? {in_data_i.exe.alu_out[XLEN-1:2], 2'b00}
                                                  : '0;
        entry_d.rmask     = is_load ? mask : '0;
        entry_d.wmask     = is_store ? mask : '0;
        entry_d.mem_wdata = is_store ? in_data_i.exe.rs2_val : '0;  // no lane shift
        entry_d.is_load   = is_load;
        entry_d.is_store  = is_store;
        entry_d.trap      = bad;
        entry_d.rd_addr   = is_store ? '0 : in_data_i.exe.instr[11:7];
    end

    stage_reg #(
        .payload_t (mem_stage_t)
    ) stage_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (entry_d),
        .out_valid_o (reg_valid),
        .out_ready_i (advance),
        .out_data_o  (out_data_o)
    );

    // trapped accesses never reach memory
    assign mem_access = (out_data_o.is_load || out_data_o.is_store) && !out_data_o.trap;
    assign advance    = out_ready_i && (!mem_access || dmem_req_ready_i);

    // request and hand-off happen in the same cycle
    assign dmem_req_valid_o = reg_valid && mem_access && out_ready_i;
    assign out_valid_o      = reg_valid && (!mem_access || dmem_req_ready_i);

    assign dmem_addr_o  = out_data_o.mem_addr;
    assign dmem_we_o    = out_data_o.is_store;
    assign dmem_mask_o  = out_data_o.rmask | out_data_o.wmask;  // one is always zero
    assign dmem_wdata_o = out_data_o.mem_wdata;

    a_mask_excl: assert property (
        @(posedge clk) disable iff (rst)
        reg_valid |-> !((|out_data_o.rmask) && (|out_data_o.wmask))
    );

endmodule : mem_request_stage

`default_nettype wire

/* logic/writeback_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module writeback_stage (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       in_valid_i,
    output logic                      in_ready_o,
    input  pipe_pkg::mem_stage_t      in_data_i,

    input  wire                       dmem_rsp_valid_i,
    input  wire [pipe_pkg::XLEN-1:0]  dmem_rdata_i,

    output logic                      commit_valid_o,
    input  wire                       commit_ready_i,
    output pipe_pkg::commit_t         commit_o
);

    import pipe_pkg::*;

    logic            pending_q;  // untrapped load waiting for data
    mem_stage_t      hold_q;
    logic            sr_ready;
    logic            sr_valid;
    logic            take;
    logic            needs_wait;
    mem_stage_t      src;
    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] load_val;
    commit_t         commit_d;

    // nothing enters while a load is outstanding
    assign in_ready_o = !pending_q && sr_ready;
    assign take       = in_valid_i && in_ready_o;
    assign needs_wait = in_data_i.is_load && !in_data_i.trap;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (take && needs_wait) begin
            pending_q <= 1'b1;
        end else if (dmem_rsp_valid_i) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold_q <= in_data_i;
        end
    end

    // commit reg is empty while pending, so the push always lands
    assign sr_valid = (take && !needs_wait) || (pending_q && dmem_rsp_valid_i);

    // pick the addressed lane and extend
    always_comb begin
        shifted = dmem_rdata_i >> {hold_q.alu_out[1:0], 3'b000};
        case (f3_load_e'(hold_q.instr[14:12]))
            LB:      load_val = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     load_val = {{(XLEN-8){1'b0}}, shifted[7:0]};
            LH:      load_val = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     load_val = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: load_val = shifted;  // lw
        endcase
    end

    always_comb begin
        src                = pending_q ? hold_q : in_data_i;
        commit_d.order     = src.order;
        commit_d.pc        = src.pc;
        commit_d.instr     = src.instr;
        commit_d.rd_addr   = src.rd_addr;
        commit_d.rd_wdata  = pending_q ? load_val : src.alu_out;
        commit_d.mem_addr  = src.mem_addr;
        commit_d.rmask     = src.rmask;
        commit_d.wmask     = src.wmask;
        commit_d.mem_wdata = src.mem_wdata;
        commit_d.trap      = src.trap;
    end

    stage_reg #(
        .payload_t (commit_t)
    ) stage_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (sr_valid),
        .in_ready_o  (sr_ready),
        .in_data_i   (commit_d),
        .out_valid_o (commit_valid_o),
        .out_ready_i (commit_ready_i),
        .out_data_o  (commit_o)
    );

    // memory answers only the load we are holding
    a_rsp_pending: assert property (
        @(posedge clk) disable iff (rst)
        dmem_rsp_valid_i |-> pending_q
    );

endmodule : writeback_stage

`default_nettype wire

/* logic/pipe_regs_top.sv */
`default_nettype none
`timescale 1ns/10ps

module pipe_regs_top (
    input  wire                          clk,
    input  wire                          rst,

    input  wire                          in_valid_i,
    output logic                         in_ready_o,
    input  pipe_pkg::exe_result_t        in_data_i,

    output logic                         dmem_req_valid_o,
    input  wire                          dmem_req_ready_i,
    output logic [pipe_pkg::XLEN-1:0]    dmem_addr_o,
    output logic                         dmem_we_o,
    output logic [pipe_pkg::MASK_W-1:0]  dmem_mask_o,
    output logic [pipe_pkg::XLEN-1:0]    dmem_wdata_o,

    input  wire                          dmem_rsp_valid_i,
    input  wire [pipe_pkg::XLEN-1:0]     dmem_rdata_i,

    output logic                         commit_valid_o,
    input  wire                          commit_ready_i,
    output pipe_pkg::commit_t            commit_o
);

    import pipe_pkg::*;

    logic       st_valid;  // stamped link
    logic       st_ready;
    stamped_t   st_data;
    logic       mem_valid; // mem link
    logic       mem_ready;
    mem_stage_t mem_data;

    order_stamp order_stamp_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .out_valid_o (st_valid),
        .out_ready_i (st_ready),
        .out_data_o  (st_data)
    );

    mem_request_stage mem_request_stage_inst (
        .clk              (clk),
        .rst              (rst),
        .in_valid_i       (st_valid),
        .in_ready_o       (st_ready),
        .in_data_i        (st_data),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_we_o        (dmem_we_o),
        .dmem_mask_o      (dmem_mask_o),
        .dmem_wdata_o     (dmem_wdata_o),
        .out_valid_o      (mem_valid),
        .out_ready_i      (mem_ready),
        .out_data_o       (mem_data)
    );

    writeback_stage writeback_stage_inst (
        .clk              (clk),
        .rst              (rst),
        .in_valid_i       (mem_valid),
        .in_ready_o       (mem_ready),
        .in_data_i        (mem_data),
        .dmem_rsp_valid_i (dmem_rsp_valid_i),
        .dmem_rdata_i     (dmem_rdata_i),
        .commit_valid_o   (commit_valid_o),
        .commit_ready_i   (commit_ready_i),
        .commit_o         (commit_o)
    );

endmodule : pipe_regs_top

`default_nettype wire

/* tests/tb_pipe_regs.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_pipe_regs;

    import pipe_pkg::*;

    typedef enum int {
        MODE_ALU,
        MODE_STORE,
        MODE_LOAD,
        MODE_TRAP,
        MODE_MIX
    } mode_e;

    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic              we;
        logic [MASK_W-1:0] mask;
        logic [XLEN-1:0]   wdata;
    } dmem_req_t;

    logic               clk;
    logic               rst;
    logic               in_valid_i;
    logic               in_ready_o;
    exe_result_t        in_data_i;
    logic               dmem_req_valid_o;
    logic               dmem_req_ready_i;
    logic [XLEN-1:0]    dmem_addr_o;
    logic               dmem_we_o;
    logic [MASK_W-1:0]  dmem_mask_o;
    logic [XLEN-1:0]    dmem_wdata_o;
    logic               dmem_rsp_valid_i;
    logic [XLEN-1:0]    dmem_rdata_i;
    logic               commit_valid_o;
    logic               commit_ready_i;
    commit_t            commit_o;
    dmem_req_t          req_seen;

    logic [31:0]        lfsr_q;
    logic [31:0]        dut_mem [64];  // memory model behind the DUT
    logic [31:0]        ref_mem [64];  // program-order copy for prediction
    commit_t            exp_q [$];
    dmem_req_t          req_q [$];
    commit_t            exp_head;
    dmem_req_t          req_head;
    logic               exp_have;
    logic               req_have;
    logic [ORDER_W-1:0] next_order;
    logic [XLEN-1:0]    rsp_data;
    int                 rsp_timer;     // cycles until the load answer
    logic               in_taken;
    logic               stall_on;
    logic               stuck;
    int                 seq;
    int                 accepted;
    int                 committed;
    int                 fail_count;
    int                 tests_run;
    int                 tests_failed;

    pipe_regs_top pipe_regs_top_inst (
        .clk              (clk),
        .rst              (rst),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .in_data_i        (in_data_i),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_we_o        (dmem_we_o),
        .dmem_mask_o      (dmem_mask_o),
        .dmem_wdata_o     (dmem_wdata_o),
        .dmem_rsp_valid_i (dmem_rsp_valid_i),
        .dmem_rdata_i     (dmem_rdata_i),
        .commit_valid_o   (commit_valid_o),
        .commit_ready_i   (commit_ready_i),
        .commit_o         (commit_o)
    );

    assign req_seen = {dmem_addr_o, dmem_we_o, dmem_mask_o, dmem_wdata_o};

    always #10 clk = ~clk;

    a_commit_expected: assert property (@(posedge clk) disable iff (rst)
        commit_valid_o && commit_ready_i |-> exp_have)
        else begin
            fail_count++;
            $display("a commit at %0t arrived with no instruction outstanding", $time);
        end

    a_commit_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid_o && commit_ready_i |-> commit_o.order == exp_head.order)
        else begin
            fail_count++;
            $display("CHECK FAILED t=%0t commit_o.order got %0d expected %0d",
                     $time, $sampled(commit_o.order), exp_head.order);
        end

    a_commit_wdata: assert property (@(posedge clk) disable iff (rst)
        commit_valid_o && commit_ready_i |-> commit_o.rd_wdata == exp_head.rd_wdata)
        else begin
            fail_count++;
            $display("CHECK FAILED t=%0t commit_o.rd_wdata got %h expected %h",
                     $time, $sampled(commit_o.rd_wdata), exp_head.rd_wdata);
        end

    a_commit_record: assert property (@(posedge clk) disable iff (rst)
        commit_valid_o && commit_ready_i |-> commit_o == exp_head)
        else begin
            fail_count++;
            $display("CHECK FAILED t=%0t commit_o got %h expected %h",
                     $time, $sampled(commit_o), exp_head);
        end

    a_commit_hold: assert property (@(posedge clk) disable iff (rst)
        commit_valid_o && !commit_ready_i |=> commit_valid_o && $stable(commit_o))
        else begin
            fail_count++;
            $display("commit record dropped or changed while stalled at %0t", $time);
        end

    a_req_expected: assert property (@(posedge clk) disable iff (rst)
        dmem_req_valid_o && dmem_req_ready_i |-> req_have)
        else begin
            fail_count++;
            $display("memory request at %0t with no untrapped access outstanding", $time);
        end

    a_req_match: assert property (@(posedge clk) disable iff (rst)
        dmem_req_valid_o && dmem_req_ready_i |-> req_seen == req_head)
        else begin
            fail_count++;
            $display("CHECK FAILED t=%0t dmem request got %h expected %h",
                     $time, $sampled(req_seen), req_head);
        end

    // valid follows writeback readiness, only the request content must hold
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        dmem_req_valid_o && !dmem_req_ready_i |=> $stable(req_seen))
        else begin
            fail_count++;
            $display("memory request changed while stalled at %0t", $time);
        end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        return (32'(a) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic exe_result_t make_instr(input mode_e mode, input int n);
        exe_result_t e;
        logic [2:0]  f3;
        logic [1:0]  w;     // 0 byte, 1 half, 2 word
        logic [1:0]  r;
        logic [1:0]  offs;
        logic [6:0]  opc;
        w    = 2'(rand_bits(2) % 3);
        r    = 2'(rand_bits(2));
        offs = 2'(rand_bits(2));
        f3   = {1'b0, w};
        opc  = 7'b0110011;
        case (mode)
            MODE_ALU:   opc = 7'b0110011;
            MODE_STORE: opc = OPC_STORE;
            MODE_LOAD: begin
                opc   = OPC_LOAD;
                f3[2] = r[0] && (w != 2'd2);  // lbu / lhu
            end
            MODE_TRAP: begin
                opc = r[0] ? OPC_LOAD : OPC_STORE;
                if (r[1]) begin
                    f3 = r[0] ? (offs[0] ? 3'd3 : {2'b11, offs[1]}) : {1'b1, offs};
                end else begin
                    f3      = offs[0] ? 3'd1 : 3'd2;  // odd half or unaligned word
                    offs[1] = offs[1] | !offs[0];
                end
            end
            MODE_MIX: begin
                opc = (r == 2'd1) ? OPC_LOAD : (r == 2'd2) ? OPC_STORE : 7'b0010011;
                f3  = 3'(rand_bits(3));
            end
        endcase
        if (mode == MODE_STORE || mode == MODE_LOAD) begin
            offs = (w == 2'd2) ? 2'b00 : (w == 2'd1) ? {offs[1], 1'b0} : offs;
        end
        e.pc      = 32'h0000_0100 + 32'(n) * 32'd4;
        e.instr   = {17'(rand_bits(17)), f3, 5'(rand_bits(5)), opc};
        e.alu_out = (opc == OPC_LOAD || opc == OPC_STORE) ?
                    {24'h00_0020, 6'(rand_bits(6)), offs} : rand_bits(32);
        e.rs2_val = rand_bits(32);
        return e;
    endfunction

    task automatic predict_commit(input exe_result_t e);
        commit_t     c;
        dmem_req_t   q;
        logic [2:0]  f3;
        logic [1:0]  offs;
        logic [5:0]  idx;
        logic        ld;
        logic        st;
        logic        bad;
        logic [3:0]  size;
        logic [31:0] sh;
        int          b;
        f3   = e.instr[14:12];
        offs = e.alu_out[1:0];
        idx  = e.alu_out[7:2];
        ld   = (e.instr[6:0] == OPC_LOAD);
        st   = (e.instr[6:0] == OPC_STORE);
        size = (f3[1:0] == 2'b00) ? 4'h1 : (f3[1:0] == 2'b01) ? 4'h3 : 4'hf;
        bad  = (ld && (f3 == 3'd3 || f3 > 3'd5)) || (st && f3 > 3'd2)
            || ((ld || st) && f3[1:0] == 2'b01 && offs[0])
            || ((ld || st) && f3[1:0] == 2'b10 && offs != 2'b00);
        c.order     = next_order;
        next_order  = next_order + 64'd1;
        c.pc        = e.pc;
        c.instr     = e.instr;
        c.rd_addr   = st ? 5'd0 : e.instr[11:7];
        c.rd_wdata  = e.alu_out;
        c.mem_addr  = (ld || st) ? {e.alu_out[31:2], 2'b00} : 32'h0;
        c.rmask     = (ld && !bad) ? (size << offs) : 4'h0;
        c.wmask     = (st && !bad) ? (size << offs) : 4'h0;
        c.mem_wdata = st ? e.rs2_val : 32'h0;
        c.trap      = bad;
        if (ld && !bad) begin
            sh = ref_mem[idx] >> {offs, 3'b000};  // addressed byte to lane 0
            case (f3)
                3'd0:    c.rd_wdata = {{24{sh[7]}}, sh[7:0]};
                3'd1:    c.rd_wdata = {{16{sh[15]}}, sh[15:0]};
                3'd4:    c.rd_wdata = {24'h0, sh[7:0]};
                3'd5:    c.rd_wdata = {16'h0, sh[15:0]};
                default: c.rd_wdata = sh;
            endcase
        end
        if (st && !bad) begin
            for (b = 0; b < MASK_W; b++) begin
                if (c.wmask[b]) ref_mem[idx][8*b +: 8] = e.rs2_val[8*b +: 8];
            end
        end
        exp_q.push_back(c);
        if ((ld || st) && !bad) begin
            q = {c.mem_addr, st, c.rmask | c.wmask, c.mem_wdata};
            req_q.push_back(q);
        end
    endtask

    // everything seen at a rising edge, before the DUT registers move
    task automatic observe_edge();
        int b;
        in_taken = in_valid_i && in_ready_o;
        if (in_taken) begin
            predict_commit(in_data_i);
            accepted++;
        end
        if (dmem_req_valid_o && dmem_req_ready_i) begin
            if (req_q.size() > 0) void'(req_q.pop_front());
            if (dmem_we_o) begin
                for (b = 0; b < MASK_W; b++) begin
                    if (dmem_mask_o[b]) begin
                        dut_mem[dmem_addr_o[7:2]][8*b +: 8] = dmem_wdata_o[8*b +: 8];
                    end
                end
            end else begin
                rsp_data  = dut_mem[dmem_addr_o[7:2]];
                rsp_timer = stall_on ? 1 + int'(rand_bits(3)) : 1 + int'(rand_bits(1));
            end
        end
        if (commit_valid_o && commit_ready_i) begin
            if (exp_q.size() > 0) void'(exp_q.pop_front());
            committed++;
        end
    endtask

    task automatic drive_cycle(input mode_e mode, input int count, inout int issued);
        if (!in_valid_i || in_taken) begin
            if (issued < count && (!stall_on || rand_bits(2) != 0)) begin
                in_data_i  = make_instr(mode, seq);
                in_valid_i = 1'b1;
                seq++;
                issued++;
            end else begin
                in_valid_i = 1'b0;
            end
        end
        dmem_req_ready_i = stall_on ? (rand_bits(2) != 0) : 1'b1;
        commit_ready_i   = stall_on ? (rand_bits(2) != 0) : 1'b1;
        dmem_rsp_valid_i = 1'b0;
        if (rsp_timer > 0) begin
            dmem_rsp_valid_i = (rsp_timer == 1);
            dmem_rdata_i     = rsp_data;
            rsp_timer--;
        end
        exp_have = exp_q.size() > 0;
        exp_head = exp_have ? exp_q[0] : '0;
        req_have = req_q.size() > 0;
        req_head = req_have ? req_q[0] : '0;
    endtask

    task automatic run_phase(input string name, input mode_e mode, input int count,
                             input logic stalls);
        int issued;
        int cycles;
        int fails_before;
        issued       = 0;
        cycles       = 0;
        fails_before = fail_count;
        stall_on     = stalls;
        tests_run++;
        if (stuck) begin
            tests_failed++;
            $display("test %s skipped, the pipeline hung in an earlier test", name);
        end else begin
            while (!stuck && (issued < count || in_valid_i || accepted != committed)) begin
                @(posedge clk);
                observe_edge();
                #2;
                drive_cycle(mode, count, issued);
                cycles++;
                if (cycles > 40 * count + 200) begin
                    stuck = 1'b1;
                    fail_count++;
                    $display("timeout in test %s, %0d accepted but %0d committed",
                             name, accepted, committed);
                end
            end
            if (fail_count == fails_before) begin
                $display("test %s ok, %0d instructions", name, count);
            end else begin
                tests_failed++;
                $display("test %s failed with %0d errors", name, fail_count - fails_before);
            end
        end
    endtask

    task automatic check_reset();
        tests_run++;
        assert (in_ready_o && !dmem_req_valid_o && !commit_valid_o) begin
            $display("test reset_state ok");
        end else begin
            fail_count++;
            tests_failed++;
            $display("outputs not idle after reset: in_ready_o=%b dmem_req_valid_o=%b",
                     in_ready_o, dmem_req_valid_o);
            $display("commit_valid_o=%b after reset", commit_valid_o);
        end
    endtask

    initial begin
        int i;
        clk              = 1'b0;
        rst              = 1'b1;
        in_valid_i       = 1'b0;
        in_data_i        = '0;
        dmem_req_ready_i = 1'b0;
        dmem_rsp_valid_i = 1'b0;
        dmem_rdata_i     = '0;
        commit_ready_i   = 1'b0;
        lfsr_q           = 32'd814;
        exp_head         = '0;
        req_head         = '0;
        exp_have         = 1'b0;
        req_have         = 1'b0;
        next_order       = '0;
        rsp_data         = '0;
        rsp_timer        = 0;
        in_taken         = 1'b0;
        stall_on         = 1'b0;
        stuck            = 1'b0;
        seq              = 0;
        accepted         = 0;
        committed        = 0;
        fail_count       = 0;
        tests_run        = 0;
        tests_failed     = 0;
        for (i = 0; i < 64; i++) begin
            dut_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        check_reset();
        run_phase("alu_only", MODE_ALU, 40, 1'b0);
        run_phase("stores", MODE_STORE, 40, 1'b0);
        run_phase("loads", MODE_LOAD, 60, 1'b0);
        run_phase("traps", MODE_TRAP, 40, 1'b0);
        run_phase("random_stalls", MODE_MIX, 400, 1'b1);
        assert (exp_q.size() == 0 && req_q.size() == 0) else begin
            fail_count++;
            $display("%0d commits and %0d memory requests never showed up",
                     exp_q.size(), req_q.size());
        end
        $display("tests run %0d, tests failed %0d, failed checks %0d, commits %0d",
                 tests_run, tests_failed, fail_count, committed);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_pipe_regs

`default_nettype wire

/* flist.f */
logic/pipe_pkg.sv
logic/stage_reg.sv
logic/order_stamp.sv
logic/mem_request_stage.sv
logic/writeback_stage.sv
logic/pipe_regs_top.sv
tests/tb_pipe_regs.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/10ps \
    --top-module tb_pipe_regs -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pipe_regs > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation returned status $run_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi
exit 0
